// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = muldivTb
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: bench/muldivTests.svh
// muldiv directed tests for multiply, divide, divide by zero, streaming, recovery and foreign ops

  logic [31:0] edgeVals [4] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
  logic [31:0] divVals [4]  = '{32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1};

  task automatic multiplyOps();
    $display("test: multiplies");
    for (int f = 0; f < 4; f++)
    begin
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++)
        begin
          issueBeat(mdOp(3'(f), edgeVals[i], edgeVals[j]), 1'b0);
          drainAll();
        end
      for (int n = 0; n < 6; n++)
      begin
        issueBeat(mdOp(3'(f), randBits(32), randBits(32)), 1'b0);
        drainAll();
      end
    end
  endtask

  task automatic divideOps();
    logic [31:0] b;
    $display("test: divides and remainders");
    for (int f = 4; f < 8; f++)
    begin
      // edge pairs where 0x80000000 / -1 hits the overflow case
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++)
        begin
          issueBeat(mdOp(3'(f), edgeVals[i], divVals[j]), 1'b0);
          drainAll();
        end
      for (int n = 0; n < 6; n++)
      begin
        b = (n < 3) ? randBits(4) + 32'd1 : randBits(32);  // small divisors too
        if (b == '0)
          b = 32'd3;
        issueBeat(mdOp(3'(f), randBits(32), b), 1'b0);
        drainAll();
      end
    end
  endtask

  task automatic zeroDivisorOps();
    $display("test: divide by zero");
    for (int f = 4; f < 8; f++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        issueBeat(mdOp(3'(f), edgeVals[i], 32'd0), 1'b0);
        drainAll();
      end
      issueBeat(mdOp(3'(f), randBits(32), 32'd0), 1'b0);
      drainAll();
    end
  endtask

  // one op per cycle so the per-op latency check forces consecutive in-order output
  task automatic mixedStream();
    logic [2:0]  fn3;
    logic [31:0] a;
    logic [31:0] b;
    $display("test: back-to-back issue");
    for (int n = 0; n < 24; n++)
    begin
      fn3 = 3'(randBits(3));
      a = randBits(32);
      b = (randBits(3) == 3'd0) ? 32'd0 : randBits(32);
      if (n % 7 == 6)
        issueBeat(makeOp(7'b0100000, fn3, OpOpcode, a, b), 1'b0);  // SUB mixed in
      else
        issueBeat(mdOp(fn3, a, b), 1'b0);
    end
    drainAll();
    idleCycles(Depth + 2);
  endtask

  task automatic recoverySquash();
    $display("test: recovery");
    issueBeat(mdOp(3'd0, randBits(32), randBits(32)), 1'b0);
    issueBeat(mdOp(3'd4, randBits(32), randBits(32)), 1'b0);
    issueBeat(mdOp(3'd3, randBits(32), randBits(32)), 1'b1);  // squashed with the rest
    issueBeat(mdOp(3'd6, randBits(32), randBits(8) + 32'd1), 1'b0);
    drainAll();
    idleCycles(Depth + 2);  // any late squashed op shows up here
  endtask

  task automatic foreignInsts();
    issuePkt_t p;
    $display("test: non-matching instructions");
    p = makeOp(7'b0000000, 3'd0, OpOpcode, randBits(32), randBits(32));  // ADD
    p.phyDestValid = 1'b1;
    issueBeat(p, 1'b0);
    drainAll();
    p = makeOp(MulDivFn7, 3'd4, 7'b0010011, randBits(32), 32'd0);  // OP-IMM with a zero src2
    p.phyDestValid = 1'b1;
    issueBeat(p, 1'b0);
    drainAll();
  endtask

// File: bench/muldivTb.sv
// muldiv unit testbench with clock, reset, DUT, operand LFSR, result model and closing report
`timescale 1ns/1ps

module muldivTb import muldivPkg::*; ();

  localparam int Depth         = 4;
  localparam int TimeoutCycles = 40;            // per drain
  localparam logic [6:0] OpOpcode  = 7'b0110011;
  localparam logic [6:0] MulDivFn7 = 7'b0000001;

  logic                clk = 1'b0;
  logic                reset;
  logic                recover;
  issuePkt_t           issuePkt;
  wbPkt_t              wbPacket;

  logic [31:0]         lfsr = 32'd31;           // seed
  logic [SeqWidth-1:0] seqCnt = '0;
  int                  cycle = 0;               // falling edges seen
  int                  checks = 0;
  int                  valueErrors = 0;
  int                  otherErrors = 0;
  wbPkt_t              expQ [$];                // oldest in flight first
  int                  issuedAt [$];

  always #5 clk = ~clk;

  muldivUnit #(
    .Depth (Depth)
  ) u_dut
  (
    .clk        (clk),
    .reset      (reset),
    .recover_i  (recover),
    .issuePkt_i (issuePkt),
    .wbPacket_o (wbPacket)
  );

  // galois form stepped once per bit handed out
  function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr = lfsr >> 1;
    if (outBit)
      lfsr = lfsr ^ 32'hA300_0000;  // taps 32 30 26 25
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsrBit()};
    return v;
  endfunction

  function automatic issuePkt_t makeOp(logic [6:0] fn7, logic [2:0] fn3, logic [6:0] opc,
                                       logic [31:0] a, logic [31:0] b);
    issuePkt_t   p;
    logic [31:0] regs;
    regs           = randBits(15);  // rs1 rs2 rd fields that the unit ignores
    p.valid        = 1'b1;
    p.seqNo        = seqCnt;
    p.phyDest      = TagWidth'(randBits(TagWidth));
    p.phyDestValid = lfsrBit();
    p.inst         = {fn7, regs[14:5], fn3, regs[4:0], opc};
    p.src1         = a;
    p.src2         = b;
    seqCnt++;
    return p;
  endfunction

  function automatic issuePkt_t mdOp(logic [2:0] fn3, logic [31:0] a, logic [31:0] b);
    return makeOp(MulDivFn7, fn3, OpOpcode, a, b);
  endfunction

  // expected writeback straight from the RV32M rules
  function automatic wbPkt_t model(issuePkt_t p);
    wbPkt_t      w;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  fn3;
    logic [63:0] prod;
    logic [31:0] quot;
    logic [31:0] rem;
    w = '0;
    a = p.src1;
    b = p.src2;
    fn3 = p.inst[14:12];
    w.valid = 1'b1;
    w.seqNo = p.seqNo;
    w.phyDest = p.phyDest;
    if (p.inst[6:0] != OpOpcode || p.inst[31:25] != MulDivFn7)
      return w;  // foreign op keeps flags and result at zero
    w.flags.executed = 1'b1;
    w.flags.destValid = p.phyDestValid;
    w.flags.exception = fn3[2] && (b == '0);
    // unsigned product corrected by 2^32 times the other operand per negative signed operand
    prod = {32'd0, a} * {32'd0, b};
    if (fn3 != 3'd3 && a[31])
      prod = prod - {b, 32'd0};  // src1 signed for MUL MULH MULHSU
    if (!fn3[1] && b[31])
      prod = prod - {a, 32'd0};  // src2 signed for MUL MULH
    if (b == '0)
    begin
      quot = '1;
      rem = a;
    end
    else if (!fn3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff)
    begin
      quot = a;  // signed overflow
      rem = '0;
    end
    else if (!fn3[0])
    begin
      quot = $signed(a) / $signed(b);
      rem = $signed(a) % $signed(b);
    end
    else
    begin
      quot = a / b;
      rem = a % b;
    end
    if (!fn3[2])
      w.result = (fn3 == 3'd0) ? prod[31:0] : prod[63:32];
    else
      w.result = fn3[1] ? rem : quot;
    return w;
  endfunction

  task automatic checkEq(input logic [63:0] got, input logic [63:0] want, input string what);
    checks++;
    if (got !== want)
    begin
      valueErrors++;
      $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, want);
    end
  endtask

  task automatic checkOutput();
    wbPkt_t want;
    int     issued;
    if (!wbPacket.valid)
      checkEq(64'(wbPacket), 64'd0, "idle writeback packet");
    else if (expQ.size() == 0)
    begin
      otherErrors++;
      $display("ERROR at %0t: writeback seqNo %0d came out with nothing in flight",
               $time, wbPacket.seqNo);
    end
    else
    begin
      want = expQ.pop_front();
      issued = issuedAt.pop_front();
      checkEq(64'(cycle - issued), 64'(Depth), $sformatf("seq %0d latency", want.seqNo));
      checkEq(64'(wbPacket.seqNo), 64'(want.seqNo), "seqNo order");
      checkEq(64'(wbPacket.phyDest), 64'(want.phyDest), $sformatf("seq %0d phyDest", want.seqNo));
      checkEq(64'(wbPacket.flags), 64'(want.flags), $sformatf("seq %0d flags", want.seqNo));
      checkEq(64'(wbPacket.result), 64'(want.result), $sformatf("seq %0d result", want.seqNo));
    end
  endtask

  // one clock cycle with the output sampled at the falling edge
  task automatic tick();
    @(negedge clk);
    cycle++;
    checkOutput();
  endtask

  task automatic issueBeat(input issuePkt_t p, input logic rec);
    issuePkt = p;
    recover = rec;
    if (rec)
    begin
      expQ.delete();      // everything not yet out is squashed
      issuedAt.delete();
    end
    else if (p.valid)
    begin
      expQ.push_back(model(p));
      issuedAt.push_back(cycle);
    end
    tick();
  endtask

  task automatic drainAll();
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < TimeoutCycles)
    begin
      issueBeat('0, 1'b0);
      waited++;
    end
    if (expQ.size() != 0)
    begin
      otherErrors++;
      $display("ERROR at %0t: timed out, %0d results never came out", $time, expQ.size());
      expQ.delete();
      issuedAt.delete();
    end
  endtask

  task automatic idleCycles(input int n);
    repeat (n) issueBeat('0, 1'b0);
  endtask

  `include "muldivTests.svh"

  initial
  begin
    reset = 1'b1;
    recover = 1'b0;
    issuePkt = '0;
    repeat (4) tick();  // output must stay idle through reset
    reset = 1'b0;
    multiplyOps();
    divideOps();
    zeroDivisorOps();
    mixedStream();
    recoverySquash();
    foreignInsts();
    idleCycles(Depth + 2);
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: hw/muldivCompute.sv
// muldiv compute stage: multiply, divide and remainder arithmetic with registered result select
`timescale 1ns/1ps

module muldivCompute import muldivPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      recover_i,
  input  stagePkt_t stage_i,
  output stagePkt_t stage_o
);

  localparam logic [Xlen-1:0] MinInt = {1'b1, {(Xlen-1){1'b0}}};  // most negative

  logic [Xlen-1:0]          a;
  logic [Xlen-1:0]          b;
  logic signed [2*Xlen-1:0] prodSS;    // signed x signed
  logic [2*Xlen-1:0]        prodUU;    // unsigned x unsigned
  logic [2*Xlen-1:0]        prodSU;    // signed x unsigned
  logic                     overflow;  // MinInt / -1
  logic [Xlen-1:0]          divS;      // sanitized signed divisor
  logic [Xlen-1:0]          divU;      // sanitized unsigned divisor
  logic [Xlen-1:0]          quotS;
  logic [Xlen-1:0]          remS;
  logic [Xlen-1:0]          quotU;
  logic [Xlen-1:0]          remU;
  logic [Xlen-1:0]          result;
  stagePkt_t                nextPkt;

  assign a = stage_i.src1;
  assign b = stage_i.src2;

  assign prodSS = $signed(a) * $signed(b);
  assign prodUU = a * b;  // zero extended to 64 by context
  // sign extend a, zero extend b; low 64 bits of the product are exact
  assign prodSU = {{Xlen{a[Xlen-1]}}, a} * {{Xlen{1'b0}}, b};

  assign overflow = (a == MinInt) && (b == '1);

  // divisor of 1 on overflow gives quotient = dividend and remainder 0 for free
  // divisor of 1 on zero keeps the divider defined, result muxed below
  assign divS = (stage_i.divZero || overflow) ? Xlen'(1) : b;
  assign divU = stage_i.divZero ? Xlen'(1) : b;

  assign quotS = $signed(a) / $signed(divS);
  assign remS  = $signed(a) % $signed(divS);
  assign quotU = a / divU;
  assign remU  = a % divU;

  always_comb
  begin
    case (stage_i.op)
      OpMul:    result = prodSS[Xlen-1:0];
      OpMulh:   result = prodSS[2*Xlen-1:Xlen];
      OpMulhsu: result = prodSU[2*Xlen-1:Xlen];
      OpMulhu:  result = prodUU[2*Xlen-1:Xlen];
      OpDiv:    result = stage_i.divZero ? '1 : quotS;  // div by 0 -> all ones
      OpDivu:   result = stage_i.divZero ? '1 : quotU;
      OpRem:    result = stage_i.divZero ? a : remS;    // rem by 0 -> dividend
      OpRemu:   result = stage_i.divZero ? a : remU;
      default:  result = '0;                           // not ours
    endcase
  end

  always_comb
  begin
    nextPkt        = stage_i;
    nextPkt.result = result;
  end

  always_ff @(posedge clk)
  begin
    stage_o <= nextPkt;
    if (reset || recover_i)
      stage_o.valid <= 1'b0;
  end

  // decode only flags zero divisor on div/rem ops
  noDivZeroOnMul: assert property (@(posedge clk) disable iff (reset)
    stage_i.valid && stage_i.divZero |-> stage_i.op inside {OpDiv, OpDivu, OpRem, OpRemu});

endmodule

// File: hw/muldivDecode.sv
// muldiv decode stage: RV32M instruction decode, zero divisor detect, operand/tag register
`timescale 1ns/1ps

module muldivDecode import muldivPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      recover_i,
  input  issuePkt_t issue_i,
  output stagePkt_t stage_o
);

  logic [OpcodeHi:0]          opcode;
  logic [Funct3Hi-Funct3Lo:0] fn3;
  logic [Funct7Hi-Funct7Lo:0] fn7;
  logic                       isMulDiv;  // opcode and funct7 both match
  logic                       isDivRem;
  stagePkt_t                  nextPkt;

  assign opcode   = issue_i.inst[OpcodeHi:0];
  assign fn3      = issue_i.inst[Funct3Hi:Funct3Lo];
  assign fn7      = issue_i.inst[Funct7Hi:Funct7Lo];
  assign isMulDiv = (opcode == OpcodeOp) && (fn7 == Fn7MulDiv);
  assign isDivRem = isMulDiv && fn3[2];  // upper half of funct3 is div/rem

  always_comb
  begin
    nextPkt         = '0;
    nextPkt.valid   = issue_i.valid;
    nextPkt.seqNo   = issue_i.seqNo;
    nextPkt.phyDest = issue_i.phyDest;
    nextPkt.src1    = issue_i.src1;
    nextPkt.src2    = issue_i.src2;
    nextPkt.op      = OpNone;  // foreign instruction stays OpNone

    if (isMulDiv)
    begin
      nextPkt.flags.executed  = 1'b1;
      nextPkt.flags.destValid = issue_i.phyDestValid;
      case (fn3)
        Fn3Mul:    nextPkt.op = OpMul;
        Fn3Mulh:   nextPkt.op = OpMulh;
        Fn3Mulhsu: nextPkt.op = OpMulhsu;
        Fn3Mulhu:  nextPkt.op = OpMulhu;
        Fn3Div:    nextPkt.op = OpDiv;
        Fn3Divu:   nextPkt.op = OpDivu;
        Fn3Rem:    nextPkt.op = OpRem;
        Fn3Remu:   nextPkt.op = OpRemu;
        default:   nextPkt.op = OpNone;
      endcase
    end

    // zero divisor raises the exception, result is still defined downstream
    if (isDivRem && (issue_i.src2 == '0))
    begin
      nextPkt.divZero         = 1'b1;
      nextPkt.flags.exception = 1'b1;
    end
  end

  // payload loads every cycle, only valid is cleared
  always_ff @(posedge clk)
  begin
    stage_o <= nextPkt;
    if (reset || recover_i)
      stage_o.valid <= 1'b0;  // squash incl. this cycle's issue
  end

  // executed clear means the op never left OpNone
  opNoneWhenIdle: assert property (@(posedge clk) disable iff (reset)
    stage_o.valid && !stage_o.flags.executed |-> stage_o.op == OpNone);

endmodule

// File: hw/muldivPkg.sv
// muldiv shared types: widths, RV32M field encodings, opcode enum and pipeline packets
package muldivPkg;

  localparam int Xlen     = 32;          // operand / result width
  localparam int SeqWidth = 8;           // sequence number
  localparam int TagWidth = 7;           // physical register tag

  // instruction word fields
  localparam int OpcodeHi = 6;
  localparam int Funct3Lo = 12;
  localparam int Funct3Hi = 14;
  localparam int Funct7Lo = 25;
  localparam int Funct7Hi = 31;

  localparam logic [6:0] OpcodeOp  = 7'b0110011; // OP major opcode
  localparam logic [6:0] Fn7MulDiv = 7'b0000001; // M extension funct7

  // funct3 encodings within MUL/DIV
  localparam logic [2:0] Fn3Mul    = 3'd0;
  localparam logic [2:0] Fn3Mulh   = 3'd1;
  localparam logic [2:0] Fn3Mulhsu = 3'd2;
  localparam logic [2:0] Fn3Mulhu  = 3'd3;
  localparam logic [2:0] Fn3Div    = 3'd4;
  localparam logic [2:0] Fn3Divu   = 3'd5;
  localparam logic [2:0] Fn3Rem    = 3'd6;
  localparam logic [2:0] Fn3Remu   = 3'd7;

  typedef enum logic [3:0] {
    OpNone,
    OpMul,
    OpMulh,
    OpMulhsu,
    OpMulhu,
    OpDiv,
    OpDivu,
    OpRem,
    OpRemu
  } muldivOp_e;

  typedef struct packed {
    logic executed;   // was a mul/div
    logic exception;  // divide by zero
    logic destValid;  // writes a register
  } exeFlags_t;

  // what the issue queue hands us
  typedef struct packed {
    logic                valid;
    logic [SeqWidth-1:0] seqNo;
    logic [TagWidth-1:0] phyDest;
    logic                phyDestValid;
    logic [31:0]         inst;
    logic [Xlen-1:0]     src1;
    logic [Xlen-1:0]     src2;
  } issuePkt_t;

  // between decode, compute and retire
  typedef struct packed {
    logic                valid;
    logic [SeqWidth-1:0] seqNo;
    logic [TagWidth-1:0] phyDest;
    muldivOp_e           op;
    exeFlags_t           flags;
    logic                divZero;   // src2 == 0 on a div/rem
    logic [Xlen-1:0]     src1;
    logic [Xlen-1:0]     src2;
    logic [Xlen-1:0]     result;    // filled in by compute
  } stagePkt_t;

  typedef struct packed {
    logic                valid;
    logic [SeqWidth-1:0] seqNo;
    logic [TagWidth-1:0] phyDest;
    exeFlags_t           flags;
    logic [Xlen-1:0]     result;
  } wbPkt_t;

endpackage

// File: hw/muldivRetire.sv
// muldiv retire: delay line padding latency to Depth, recovery squash, writeback packing
`timescale 1ns/1ps

module muldivRetire import muldivPkg::*;
#(
  parameter int Depth = 4
)
(
  input  logic      clk,
  input  logic      reset,
  input  logic      recover_i,
  input  stagePkt_t stage_i,
  output wbPkt_t    wbPacket_o
);

  // decode and compute take one cycle each, the rest sits here
  localparam int Stages = (Depth > 3) ? Depth - 2 : 1;

  wbPkt_t entry;             // compute output trimmed to writeback fields
  wbPkt_t pipeQ [Stages];    // [0] youngest
  wbPkt_t last;

  always_comb
  begin
    entry.valid   = stage_i.valid;
    entry.seqNo   = stage_i.seqNo;
    entry.phyDest = stage_i.phyDest;
    entry.flags   = stage_i.flags;
    entry.result  = stage_i.result;
  end

  always_ff @(posedge clk)
  begin
    pipeQ[0] <= entry;
    for (int i = 1; i < Stages; i++)
      pipeQ[i] <= pipeQ[i-1];
    if (reset || recover_i)
    begin
      for (int i = 0; i < Stages; i++)
        pipeQ[i].valid <= 1'b0;  // drop everything in flight
    end
  end

  assign last = pipeQ[Stages-1];

  // idle slot drives all zeros so stale tags never leak out
  always_comb
  begin
    if (last.valid)
      wbPacket_o = last;
    else
      wbPacket_o = '0;
  end

  // two fixed stages ahead of this one, so three is the floor
  depthMin: assert property (@(posedge clk) Depth >= 3);

  // exception only ever comes with an executed div/rem
  excImpliesExec: assert property (@(posedge clk) disable iff (reset)
    wbPacket_o.flags.exception |-> wbPacket_o.valid && wbPacket_o.flags.executed);

endmodule

// File: hw/muldivUnit.sv
// muldiv unit top: pipelined RV32M multiply/divide, decode -> compute -> retire delay line
`timescale 1ns/1ps

module muldivUnit import muldivPkg::*;
#(
  parameter int Depth = 4  // issue to writeback latency, min 3
)
(
  input  logic      clk,
  input  logic      reset,
  input  logic      recover_i,   // squash all in flight
  input  issuePkt_t issuePkt_i,
  output wbPkt_t    wbPacket_o
);

  stagePkt_t decStage;  // decode -> compute
  stagePkt_t cmpStage;  // compute -> retire

  // stage 1, decode and operand capture
  muldivDecode u_decode
  (
    .clk       (clk),
    .reset     (reset),
    .recover_i (recover_i),
    .issue_i   (issuePkt_i),
    .stage_o   (decStage)
  );

  // stage 2, arithmetic
  muldivCompute u_compute
  (
    .clk       (clk),
    .reset     (reset),
    .recover_i (recover_i),
    .stage_i   (decStage),
    .stage_o   (cmpStage)
  );

  // remaining Depth-2 cycles
  muldivRetire #(
    .Depth (Depth)
  ) u_retire
  (
    .clk        (clk),
    .reset      (reset),
    .recover_i  (recover_i),
    .stage_i    (cmpStage),
    .wbPacket_o (wbPacket_o)
  );

endmodule

// File: sim.f
+incdir+bench
hw/muldivPkg.sv
hw/muldivDecode.sv
hw/muldivCompute.sv
hw/muldivRetire.sv
hw/muldivUnit.sv
bench/muldivTb.sv
